//--- hw/core_pkg.sv
package core_pkg;

    // Major opcodes handled by this slice
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // LUI passes the immediate straight through
    } alu_op_e;

    // One decoded instruction on its way from decode to execute
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] data1;     // Value of rs1
        logic [31:0] data2;     // Value of rs2
        logic [31:0] imm;
        logic [4:0]  rd;
        alu_op_e     alu_op;
        logic        use_imm;   // Operand B comes from imm
        logic        use_pc;    // Operand A comes from pc
        logic        wr_reg_n;  // Low when the result is written back
        logic [2:0]  funct3;
    } id_ex_t;

    // Retirement record, also the register file write port
    typedef struct packed {
        logic        wr_reg_n;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
    } retire_t;

endpackage

//--- hw/core_slice_top.sv
`timescale 1ns/1ns

module core_slice_top
    import core_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic        instr_valid,
    input  logic        stall,
    output logic        hold,
    output retire_t     retire
);

    id_ex_t      dec;
    id_ex_t      ex;
    logic        interlock;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    // The source keeps instr and pc steady while this is high
    assign hold = stall || interlock;

    instr_decode u_decode (
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid),
        .ex          (ex),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dec         (dec),
        .interlock   (interlock)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr       (retire)
    );

    id_ex_regs #(
        .RESET_PC (RESET_PC)
    ) u_id_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .interlock (interlock),
        .dec       (dec),
        .ex        (ex)
    );

    execute_stage u_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex     (ex),
        .retire (retire)
    );

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ns

module execute_stage
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  id_ex_t  ex,
    output retire_t retire
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] result;
    logic        wr_reg_n_q;
    logic [4:0]  rd_q;
    logic [31:0] data_q;
    logic [31:0] pc_q;

    assign op_a  = ex.use_pc ? ex.pc : ex.data1;
    assign op_b  = ex.use_imm ? ex.imm : ex.data2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result = {31'd0, op_a < op_b};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_reg_n_q <= 1'b1;
        end else begin
            wr_reg_n_q <= ex.wr_reg_n;  // Never stalls, a bubble retires as a bubble
        end
    end

    always_ff @(posedge clk) begin
        rd_q   <= ex.rd;
        data_q <= result;
        pc_q   <= ex.pc;
    end

    assign retire = '{
        wr_reg_n: wr_reg_n_q,
        rd:       rd_q,
        data:     data_q,
        pc:       pc_q
    };

    // A live instruction must never write an unknown value back
    live_result_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !ex.wr_reg_n |-> !$isunknown(result)
    ) else $error("live instruction in EX has an unknown result");

endmodule

//--- hw/id_ex_regs.sv
`timescale 1ns/1ns

module id_ex_regs
    import core_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall,
    input  logic   interlock,
    input  id_ex_t dec,
    output id_ex_t ex
);

    logic freeze;

    assign freeze = stall || interlock;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex <= '{
                pc:       RESET_PC,
                data1:    32'd0,
                data2:    32'd0,
                imm:      32'd0,
                rd:       5'd0,
                alu_op:   ALU_ADD,
                use_imm:  1'b0,
                use_pc:   1'b0,
                wr_reg_n: 1'b1,
                funct3:   3'd0
            };
        end else if (freeze) begin
            // Contents stay, but the held copy must not retire a second time
            ex.wr_reg_n <= 1'b1;
        end else begin
            ex <= dec;
        end
    end

    // A held entry is a bubble, so the interlock it caused clears next cycle
    interlock_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        interlock |=> !interlock
    ) else $error("interlock lasted more than one cycle");

endmodule

//--- hw/instr_decode.sv
`timescale 1ns/1ns

module instr_decode
    import core_pkg::*;
(
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic        instr_valid,
    input  id_ex_t      ex,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output id_ex_t      dec,
    output logic        interlock
);

    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm;
    alu_op_e     alu_op;
    logic        use_imm;
    logic        use_pc;
    logic        use_rs1;
    logic        use_rs2;
    logic        writes;
    logic        hit_rs1;
    logic        hit_rs2;

    // Shared funct3 map of OP and OP_IMM, SUB exists only in the register form
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt,
                                             input logic reg_form);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && reg_form) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign imm_i    = {{20{instr[31]}}, instr[31:20]};
    assign imm_u    = {instr[31:12], 12'd0};

    always_comb begin
        alu_op  = ALU_ADD;
        imm     = 32'd0;
        use_imm = 1'b0;
        use_pc  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        writes  = 1'b0;
        case (opcode_e'(instr[6:0]))
            OPC_OP: begin
                alu_op  = funct_to_alu(funct3, instr[30], 1'b1);
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                writes  = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op  = funct_to_alu(funct3, instr[30], 1'b0);
                imm     = imm_i;  // Shifts only look at the low five bits
                use_imm = 1'b1;
                use_rs1 = 1'b1;
                writes  = 1'b1;
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                imm     = imm_u;
                use_imm = 1'b1;
                writes  = 1'b1;
            end
            OPC_AUIPC: begin
                imm     = imm_u;
                use_imm = 1'b1;
                use_pc  = 1'b1;
                writes  = 1'b1;
            end
            default: writes = 1'b0;  // Anything else travels as a bubble
        endcase
    end

    assign dec = '{
        pc:       pc,
        data1:    rs1_data,
        data2:    rs2_data,
        imm:      imm,
        rd:       rd,
        alu_op:   alu_op,
        use_imm:  use_imm,
        use_pc:   use_pc,
        wr_reg_n: !(instr_valid && writes && (rd != 5'd0)),
        funct3:   funct3
    };

    // The producer in EX has not reached the register file yet
    assign hit_rs1   = use_rs1 && (rs1_addr == ex.rd);
    assign hit_rs2   = use_rs2 && (rs2_addr == ex.rd);
    assign interlock = instr_valid && !ex.wr_reg_n && (hit_rs1 || hit_rs2);

    // A live producer in EX never targets x0
    interlock_not_on_x0: assert final (!interlock || (ex.rd != 5'd0))
        else $error("interlock raised against x0");

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ns

module reg_file
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  retire_t     wr
);

    logic [31:0] regs [1:31];  // x0 has no storage
    logic        wr_en;

    assign wr_en = !wr.wr_reg_n && (wr.rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Write-through lets decode see the instruction retiring this cycle
    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 :
                      (wr_en && (wr.rd == rs1_addr)) ? wr.data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 :
                      (wr_en && (wr.rd == rs2_addr)) ? wr.data : regs[rs2_addr];

    // Decode never asks for a write to x0
    no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !wr.wr_reg_n |-> (wr.rd != 5'd0)
    ) else $error("write attempted to x0");

endmodule

//--- test/tb_core_slice.sv
`timescale 1ns/1ns

module tb_core_slice
    import core_pkg::*;
;

    localparam int          NUM_INSTR      = 2000;
    localparam int          RESET_CYCLES   = 16;
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * 4 + 200;
    localparam logic [31:0] SEED           = 32'h9b799d09;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
        logic [31:0] accept_edge;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        instr_valid;
    logic        stall;
    logic        hold;
    retire_t     retire;

    logic [31:0] mregs [0:31];  // Architectural state of the reference model
    expect_t     exp_q [$];
    logic [4:0]  prev_rd;       // Destination now sitting in EX, zero for a bubble
    logic [31:0] next_pc = 32'd0;
    int          edge_cnt = 0;
    int          accepted = 0;
    int          presented = 0;
    int          n_interlock = 0;
    int          cycle_cnt = 0;

    core_slice_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid),
        .stall       (stall),
        .hold        (hold),
        .retire      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the instruction stream did not drain in %0d cycles",
                     TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // Small register indices keep hazards frequent
    function automatic logic [31:0] gen_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [19:0] upper;
        rd    = $urandom_range(0, 3);
        rs1   = $urandom_range(0, 3);
        rs2   = $urandom_range(0, 3);
        f3    = $urandom_range(0, 7);
        alt   = $urandom_range(0, 1);
        imm   = 12'($urandom());
        upper = 20'($urandom());
        if (f3 == 3'd1) imm[11:5] = 7'h00;
        if (f3 == 3'd5) imm[11:5] = alt ? 7'h20 : 7'h00;  // SRAI or SRLI
        case ($urandom_range(0, 3))
            0: return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                       rs2, rs1, f3, rd, OPC_OP};
            1: return {imm, rs1, f3, rd, OPC_OP_IMM};
            2: return {upper, rd, OPC_LUI};
            default: return {upper, rd, OPC_AUIPC};
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return sa >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] model_result(input logic [31:0] ins,
                                                 input logic [31:0] ipc);
        logic [2:0] f3;
        f3 = ins[14:12];
        case (ins[6:0])
            OPC_LUI:   return {ins[31:12], 12'd0};
            OPC_AUIPC: return ipc + {ins[31:12], 12'd0};
            OPC_OP:    return alu_ref(f3, ins[30] && (f3 == 3'd0 || f3 == 3'd5),
                                      mregs[ins[19:15]], mregs[ins[24:20]]);
            default:   return alu_ref(f3, ins[30] && (f3 == 3'd5), mregs[ins[19:15]],
                                      {{20{ins[31]}}, ins[31:20]});
        endcase
    endfunction

    // True when the instruction reads register r as a source
    function automatic logic reads_reg(input logic [31:0] ins, input logic [4:0] r);
        if (r == 5'd0) return 1'b0;
        case (ins[6:0])
            OPC_OP:     return (ins[19:15] == r) || (ins[24:20] == r);
            OPC_OP_IMM: return ins[19:15] == r;
            default:    return 1'b0;
        endcase
    endfunction

    task automatic run_edge();
        logic        accept;
        logic        exp_hold;
        logic [31:0] data;
        expect_t     head;
        @(posedge clk);
        edge_cnt++;
        if (!retire.wr_reg_n) begin
            check_equal(exp_q.size() != 0, 1'b1, "retirement with nothing expected");
            head = exp_q.pop_front();
            check_equal(retire.rd, head.rd, "retire rd");
            check_equal(retire.data, head.data, "retire data");
            check_equal(retire.pc, head.pc, "retire pc");
            check_equal(edge_cnt, head.accept_edge + 2, "retire edge after acceptance");
        end else if (exp_q.size() != 0) begin
            check_equal(exp_q[0].accept_edge + 2 > edge_cnt, 1'b1, "retirement on time");
        end
        exp_hold = stall || (instr_valid && reads_reg(instr, prev_rd));
        check_equal(hold, exp_hold, "hold");
        if (instr_valid && !stall && exp_hold) n_interlock++;
        accept  = instr_valid && !exp_hold;
        prev_rd = 5'd0;  // A frozen or empty slot leaves a bubble in EX
        if (accept) begin
            data = model_result(instr, pc);
            if (instr[11:7] != 5'd0) begin
                mregs[instr[11:7]] = data;
                exp_q.push_back('{rd: instr[11:7], data: data, pc: pc, accept_edge: edge_cnt});
                prev_rd = instr[11:7];
            end
            next_pc = pc + 32'd4;
            accepted++;
        end
        stall <= ($urandom_range(0, 7) == 0);
        if (!instr_valid || accept) begin
            pc <= next_pc;
            if (presented < NUM_INSTR && $urandom_range(0, 7) != 0) begin
                instr       <= gen_instr();
                instr_valid <= 1'b1;
                presented++;
            end else begin
                instr       <= $urandom();  // Garbage in a gap must stay a bubble
                instr_valid <= 1'b0;
            end
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr       = 32'd0;
        pc          = 32'd0;
        instr_valid = 1'b0;
        stall       = 1'b0;
        prev_rd     = 5'd0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = 32'd0;
        end
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        check_equal(retire.wr_reg_n, 1'b1, "retire write flag in reset");
        rst_n <= 1'b1;
        while (accepted < NUM_INSTR || exp_q.size() != 0) begin
            run_edge();
        end
        repeat (8) run_edge();  // Nothing may retire once the stream is done
        check_equal(exp_q.size(), 0, "expected queue empty after drain");
        check_equal(n_interlock != 0, 1'b1, "interlock exercised");
        $display("** PASS **");
        $finish;
    end

endmodule

//--- verilog.f
hw/core_pkg.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/id_ex_regs.sv
hw/execute_stage.sv
hw/core_slice_top.sv
test/tb_core_slice.sv
